/* logic/loader_consts.svh */
// Sizing constants for the firmware loader path
// LDR_IMEM_ADDR_W is a byte address, so the memory holds 2**(W-2) words
// LDR_FRAME_BYTES must be a multiple of 4 so that frames end on word boundaries
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// Data bytes in one frame, checksum excluded
`define LDR_FRAME_BYTES 128

// Word that stops further memory writes for the rest of a load
`define LDR_STOP_WORD 32'h1A1A1A1A

// Receive FIFO depth as a power of two
`define LDR_FIFO_DEPTH_LOG2 4

// Byte address width of the instruction memory, 256 words
`define LDR_IMEM_ADDR_W 10

`endif

/* logic/xmodem_pkg.sv */
// Protocol-side types of the loader
// Control byte values follow XMODEM checksum mode only
`default_nettype none

package xmodem_pkg;

    // Bytes with a fixed meaning on the link
    typedef enum logic [7:0] {
        SOH = 8'h01,
        EOT = 8'h04,
        ACK = 8'h06,
        NAK = 8'h15
    } ctrl_byte_e;

    // Loader FSM states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_SOH,
        BLOCK_NUM,
        BLOCK_INV,
        DATA
    } ldr_state_e;

    // One-cycle reply strobe towards the host
    typedef struct packed {
        logic       valid;
        ctrl_byte_e code;
    } reply_t;

endpackage

`default_nettype wire

/* logic/imem_pkg.sv */
// Memory-side types of the loader
// Write address is a byte address, the low two bits are ignored by the memory
`default_nettype none

`include "loader_consts.svh"

package imem_pkg;

    typedef logic [31:0] instr_word_t;

    // Single-cycle word write request
    typedef struct packed {
        logic                         en;
        logic [`LDR_IMEM_ADDR_W-1:0] addr;
        instr_word_t                  data;
    } imem_wr_t;

endpackage

`default_nettype wire

/* logic/byte_fifo.sv */
// Show-ahead byte FIFO for received host bytes
// A push into a full FIFO is dropped; a pop from an empty FIFO is ignored
// Flush empties the FIFO and wins over a push in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "loader_consts.svh"

module byte_fifo #(
    parameter int DEPTH_LOG2 = `LDR_FIFO_DEPTH_LOG2
) (
    input  wire logic       clk,
    input  wire logic       i_rst,
    input  wire logic       i_push,
    input  wire logic [7:0] i_push_byte,
    input  wire logic       i_pop,
    input  wire logic       i_flush,
    output logic      [7:0] o_head,
    output logic            o_empty,
    output logic            o_full
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    logic [7:0]            mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  push_ok;
    logic                  pop_ok;

    assign o_empty = (count == '0);
    assign o_full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    // Head byte is valid whenever the FIFO is not empty
    assign o_head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok && !i_flush) begin
            mem[wr_ptr] <= i_push_byte;
        end
    end

endmodule

`default_nettype wire

/* logic/xmodem_loader.sv */
// XMODEM checksum-mode loader into the instruction memory
// Block numbers are not checked against the expected sequence
// A bad checksum rewinds the write address to the start of that frame
// A bad inverted block number aborts to IDLE until the next i_start
`timescale 1ns/1ps
`default_nettype none

`include "loader_consts.svh"

module xmodem_loader (
    input  wire logic             clk,
    input  wire logic             i_rst,
    input  wire logic             i_start,
    input  wire logic             i_rx_empty,
    input  wire logic [7:0]       i_rx_byte,
    output logic                  o_rx_pop,
    output logic                  o_rx_flush,
    output imem_pkg::imem_wr_t    o_imem_wr,
    output xmodem_pkg::reply_t    o_reply,
    output logic                  o_done
);

    localparam int CNT_W = $clog2(`LDR_FRAME_BYTES) + 1;

    xmodem_pkg::ldr_state_e       state_q;
    xmodem_pkg::ldr_state_e       state_d;
    logic [CNT_W-1:0]             cnt_q;
    logic [CNT_W-1:0]             cnt_d;
    logic [7:0]                   cksum_q;
    logic [7:0]                   cksum_d;
    logic [7:0]                   blk_q;
    logic [7:0]                   blk_d;
    imem_pkg::instr_word_t        word_q;
    imem_pkg::instr_word_t        word_d;
    logic [`LDR_IMEM_ADDR_W-1:0] addr_q;
    logic [`LDR_IMEM_ADDR_W-1:0] addr_d;
    logic [`LDR_IMEM_ADDR_W-1:0] frame_addr_q;
    logic [`LDR_IMEM_ADDR_W-1:0] frame_addr_d;
    logic                         inhibit_q;
    logic                         inhibit_d;

    // Registered outputs
    logic                         wr_en_q;
    logic                         wr_en_d;
    logic [`LDR_IMEM_ADDR_W-1:0] wr_addr_q;
    logic [`LDR_IMEM_ADDR_W-1:0] wr_addr_d;
    imem_pkg::instr_word_t        wr_data_q;
    imem_pkg::instr_word_t        wr_data_d;
    logic                         reply_valid_q;
    logic                         reply_valid_d;
    xmodem_pkg::ctrl_byte_e       reply_code_q;
    xmodem_pkg::ctrl_byte_e       reply_code_d;
    logic                         done_q;
    logic                         done_d;

    // Consume one byte per cycle while active
    assign o_rx_pop   = (state_q != xmodem_pkg::IDLE) && !i_rx_empty;
    assign o_rx_flush = (state_q == xmodem_pkg::IDLE) && i_start;

    assign o_imem_wr.en    = wr_en_q;
    assign o_imem_wr.addr  = wr_addr_q;
    assign o_imem_wr.data  = wr_data_q;
    assign o_reply.valid   = reply_valid_q;
    assign o_reply.code    = reply_code_q;
    assign o_done          = done_q;

    always_comb begin
        state_d       = state_q;
        cnt_d         = cnt_q;
        cksum_d       = cksum_q;
        blk_d         = blk_q;
        word_d        = word_q;
        addr_d        = addr_q;
        frame_addr_d  = frame_addr_q;
        inhibit_d     = inhibit_q;
        wr_en_d       = 1'b0;
        wr_addr_d     = wr_addr_q;
        wr_data_d     = wr_data_q;
        reply_valid_d = 1'b0;
        reply_code_d  = reply_code_q;
        done_d        = 1'b0;

        case (state_q)
            xmodem_pkg::IDLE: begin
                // Arm a new load from address 0
                if (i_start) begin
                    state_d      = xmodem_pkg::WAIT_SOH;
                    inhibit_d    = 1'b0;
                    addr_d       = '0;
                    frame_addr_d = '0;
                end
            end

            xmodem_pkg::WAIT_SOH: begin
                if (o_rx_pop) begin
                    if (i_rx_byte == xmodem_pkg::SOH) begin
                        state_d = xmodem_pkg::BLOCK_NUM;
                    end else if (i_rx_byte == xmodem_pkg::EOT) begin
                        state_d       = xmodem_pkg::IDLE;
                        reply_valid_d = 1'b1;
                        reply_code_d  = xmodem_pkg::ACK;
                        done_d        = 1'b1;
                        addr_d        = '0;
                        frame_addr_d  = '0;
                    end
                    // Anything else is noise between frames
                end
            end

            xmodem_pkg::BLOCK_NUM: begin
                if (o_rx_pop) begin
                    blk_d   = i_rx_byte;
                    state_d = xmodem_pkg::BLOCK_INV;
                end
            end

            xmodem_pkg::BLOCK_INV: begin
                if (o_rx_pop) begin
                    if (i_rx_byte == ~blk_q) begin
                        state_d = xmodem_pkg::DATA;
                        cnt_d   = '0;
                        cksum_d = '0;
                    end else begin
                        state_d       = xmodem_pkg::IDLE;
                        reply_valid_d = 1'b1;
                        reply_code_d  = xmodem_pkg::NAK;
                    end
                end
            end

            xmodem_pkg::DATA: begin
                if (o_rx_pop) begin
                    if (cnt_q == CNT_W'(`LDR_FRAME_BYTES)) begin
                        // Checksum byte closes the frame
                        state_d       = xmodem_pkg::WAIT_SOH;
                        reply_valid_d = 1'b1;
                        if (i_rx_byte == cksum_q) begin
                            reply_code_d = xmodem_pkg::ACK;
                            frame_addr_d = addr_q;
                        end else begin
                            reply_code_d = xmodem_pkg::NAK;
                            addr_d       = frame_addr_q;
                        end
                    end else begin
                        word_d  = {i_rx_byte, word_q[31:8]};
                        cksum_d = cksum_q + i_rx_byte;
                        cnt_d   = cnt_q + 1'b1;
                        // Fourth byte completes a little-endian word
                        if (cnt_q[1:0] == 2'b11) begin
                            wr_en_d   = !inhibit_q;
                            wr_addr_d = addr_q;
                            wr_data_d = word_d;
                            addr_d    = addr_q + `LDR_IMEM_ADDR_W'(4);
                            if (word_d == `LDR_STOP_WORD) begin
                                inhibit_d = 1'b1;
                            end
                        end
                    end
                end
            end

            default: begin
                state_d = xmodem_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q       <= xmodem_pkg::IDLE;
            cnt_q         <= '0;
            cksum_q       <= '0;
            addr_q        <= '0;
            frame_addr_q  <= '0;
            inhibit_q     <= 1'b0;
            wr_en_q       <= 1'b0;
            reply_valid_q <= 1'b0;
            done_q        <= 1'b0;
        end else begin
            state_q       <= state_d;
            cnt_q         <= cnt_d;
            cksum_q       <= cksum_d;
            addr_q        <= addr_d;
            frame_addr_q  <= frame_addr_d;
            inhibit_q     <= inhibit_d;
            wr_en_q       <= wr_en_d;
            reply_valid_q <= reply_valid_d;
            done_q        <= done_d;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        blk_q        <= blk_d;
        word_q       <= word_d;
        wr_addr_q    <= wr_addr_d;
        wr_data_q    <= wr_data_d;
        reply_code_q <= reply_code_d;
    end

endmodule

`default_nettype wire

/* logic/instr_mem.sv */
// Word-organized instruction memory
// Addresses are byte addresses; the low two bits are ignored
// No reset, contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

`include "loader_consts.svh"

module instr_mem #(
    parameter int ADDR_W = `LDR_IMEM_ADDR_W
) (
    input  wire logic              clk,
    input  wire imem_pkg::imem_wr_t i_wr,
    input  wire logic [ADDR_W-1:0] i_rd_addr,
    output imem_pkg::instr_word_t  o_rd_data
);

    localparam int WORDS = 2 ** (ADDR_W - 2);

    imem_pkg::instr_word_t mem [WORDS];

    // Loader write port
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr[ADDR_W-1:2]] <= i_wr.data;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr[ADDR_W-1:2]];
    end

endmodule

`default_nettype wire

/* logic/fw_load_top.sv */
// Firmware load path: receive FIFO, XMODEM loader and instruction memory
// The host byte link has no back-pressure; overflow drops bytes
`timescale 1ns/1ps
`default_nettype none

`include "loader_consts.svh"

module fw_load_top (
    input  wire logic                         clk,
    input  wire logic                         i_rst,
    input  wire logic                         i_start,
    input  wire logic                         i_rx_valid,
    input  wire logic [7:0]                   i_rx_byte,
    output logic                              o_rx_full,
    output xmodem_pkg::reply_t                o_reply,
    output logic                              o_done,
    input  wire logic [`LDR_IMEM_ADDR_W-1:0] i_rd_addr,
    output imem_pkg::instr_word_t             o_rd_data
);

    logic               rx_empty;
    logic [7:0]         rx_head;
    logic               rx_pop;
    logic               rx_flush;
    imem_pkg::imem_wr_t imem_wr;

    byte_fifo #(
        .DEPTH_LOG2 (`LDR_FIFO_DEPTH_LOG2)
    ) u_rx_fifo (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_push      (i_rx_valid),
        .i_push_byte (i_rx_byte),
        .i_pop       (rx_pop),
        .i_flush     (rx_flush),
        .o_head      (rx_head),
        .o_empty     (rx_empty),
        .o_full      (o_rx_full)
    );

    xmodem_loader u_loader (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_rx_empty (rx_empty),
        .i_rx_byte  (rx_head),
        .o_rx_pop   (rx_pop),
        .o_rx_flush (rx_flush),
        .o_imem_wr  (imem_wr),
        .o_reply    (o_reply),
        .o_done     (o_done)
    );

    instr_mem #(
        .ADDR_W (`LDR_IMEM_ADDR_W)
    ) u_imem (
        .clk       (clk),
        .i_wr      (imem_wr),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// Free-running testbench clock
// Period is 8 ns, first rising edge at 4 ns
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* test/tb_fw_load.sv */
// Testbench for the firmware load path
// Host bytes are pushed with 1 to 3 idle cycles between them, slower than the pop rate
// Memory words that no load has written are not read back
`timescale 1ns/1ps
`default_nettype none

`include "loader_consts.svh"

module tb_fw_load;

    localparam int WORDS        = 2 ** (`LDR_IMEM_ADDR_W - 2);
    localparam int FRAME_WORDS  = `LDR_FRAME_BYTES / 4;
    localparam int REPLY_WAIT   = 200;
    localparam int QUIET_CYCLES = 300;

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic                        rx_valid;
    logic [7:0]                  rx_byte;
    logic                        rx_full;
    xmodem_pkg::reply_t          reply;
    logic                        done;
    logic [`LDR_IMEM_ADDR_W-1:0] rd_addr;
    imem_pkg::instr_word_t       rd_data;

    // Bytes of the frame being sent
    logic [7:0] frame_data [`LDR_FRAME_BYTES];

    // Expected memory image and loader address model, in words
    imem_pkg::instr_word_t exp_mem [WORDS];
    bit                    exp_valid [WORDS];
    int                    model_addr;
    int                    model_frame_addr;
    bit                    model_inhibit;

    // Events seen by the monitor
    logic [7:0] reply_q [$];
    bit         done_q [$];

    tb_clock u_clock (
        .o_clk (clk)
    );

    fw_load_top u_dut (
        .clk        (clk),
        .i_rst      (rst),
        .i_start    (start),
        .i_rx_valid (rx_valid),
        .i_rx_byte  (rx_byte),
        .o_rx_full  (rx_full),
        .o_reply    (reply),
        .o_done     (done),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (rd_data)
    );

    // Sampled on the falling edge, where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (reply.valid) begin
                reply_q.push_back(reply.code);
            end
            if (done) begin
                done_q.push_back(reply.valid && (reply.code == xmodem_pkg::ACK));
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s at %0t", what, $time);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    // Additive checksum over the data bytes
    function automatic logic [7:0] frame_checksum();
        logic [7:0] sum;
        sum = 8'h00;
        for (int i = 0; i < `LDR_FRAME_BYTES; i++) begin
            sum = sum + frame_data[i];
        end
        return sum;
    endfunction

    // Applies one frame to the expected image and returns the expected reply
    function automatic logic [7:0] model_frame(input logic [7:0] sent_cksum);
        logic [31:0] word;
        for (int w = 0; w < FRAME_WORDS; w++) begin
            word = {frame_data[4*w+3], frame_data[4*w+2], frame_data[4*w+1], frame_data[4*w]};
            if (!model_inhibit) begin
                exp_mem[model_addr]   = word;
                exp_valid[model_addr] = 1'b1;
            end
            if (word == `LDR_STOP_WORD) begin
                model_inhibit = 1'b1;
            end
            model_addr = (model_addr + 1) % WORDS;
        end
        if (sent_cksum == frame_checksum()) begin
            model_frame_addr = model_addr;
            return xmodem_pkg::ACK;
        end
        // Bad checksum rewinds to the frame start
        model_addr = model_frame_addr;
        return xmodem_pkg::NAK;
    endfunction

    function automatic void fill_random();
        for (int i = 0; i < `LDR_FRAME_BYTES; i++) begin
            frame_data[i] = 8'($urandom);
        end
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = 1 + int'($urandom % 3);
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_byte  <= b;
        @(posedge clk);
        rx_valid <= 1'b0;
        repeat (gap - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] blk, input logic [7:0] blk_inv,
                              input logic [7:0] cksum);
        send_byte(xmodem_pkg::SOH);
        send_byte(blk);
        send_byte(blk_inv);
        for (int i = 0; i < `LDR_FRAME_BYTES; i++) begin
            send_byte(frame_data[i]);
        end
        send_byte(cksum);
    endtask

    task automatic expect_reply(input logic [7:0] code, input string what);
        int waited;
        waited = 0;
        while (reply_q.size() == 0) begin
            if (waited == REPLY_WAIT) begin
                fail_now({"No reply arrived for ", what});
            end
            @(negedge clk);
            waited++;
        end
        check_value({"o_reply.code for ", what}, {24'h0, reply_q.pop_front()}, {24'h0, code});
    endtask

    task automatic run_frame(input logic [7:0] blk, input logic [7:0] cksum,
                             input string what);
        logic [7:0] code;
        code = model_frame(cksum);
        send_frame(blk, ~blk, cksum);
        expect_reply(code, what);
    endtask

    task automatic start_load();
        check_value("o_done pulses before start", done_q.size(), 0);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        model_addr       = 0;
        model_frame_addr = 0;
        model_inhibit    = 1'b0;
    endtask

    // EOT gets ACK together with a single o_done pulse
    task automatic finish_load(input string what);
        send_byte(xmodem_pkg::EOT);
        expect_reply(xmodem_pkg::ACK, {"EOT of ", what});
        check_value("o_done pulses", done_q.size(), 1);
        check_value("o_done with EOT ACK", {31'h0, done_q.pop_front()}, 1);
        model_addr       = 0;
        model_frame_addr = 0;
    endtask

    task automatic check_memory(input string what);
        for (int w = 0; w < WORDS; w++) begin
            if (exp_valid[w]) begin
                @(posedge clk);
                rd_addr <= `LDR_IMEM_ADDR_W'(w * 4);
                @(posedge clk);
                @(negedge clk);
                check_value($sformatf("o_rd_data at 0x%03h after %s", w * 4, what),
                            rd_data, exp_mem[w]);
            end
        end
    endtask

    // Loader is aborted, so nothing may come back
    task automatic watch_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_value("o_reply count while aborted", reply_q.size(), 0);
            check_value("o_done count while aborted", done_q.size(), 0);
        end
    endtask

    initial begin
        logic [7:0] good_sum;
        logic [7:0] bad_inv;
        void'($urandom(32'h8428_f070));
        rst              = 1'b1;
        start            = 1'b0;
        rx_valid         = 1'b0;
        rx_byte          = 8'h00;
        rd_addr          = '0;
        model_addr       = 0;
        model_frame_addr = 0;
        model_inhibit    = 1'b0;
        for (int w = 0; w < WORDS; w++) begin
            exp_valid[w] = 1'b0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("o_rx_full after reset", {31'h0, rx_full}, 0);
        check_value("o_reply.valid after reset", {31'h0, reply.valid}, 0);
        check_value("o_done after reset", {31'h0, done}, 0);

        // Three random frames
        start_load();
        for (int f = 1; f <= 3; f++) begin
            fill_random();
            run_frame(8'(f), frame_checksum(), $sformatf("frame %0d of first load", f));
        end
        finish_load("first load");
        check_memory("first load");

        // Second load starts again at address 0
        start_load();
        fill_random();
        run_frame(8'd1, frame_checksum(), "frame 1 of reload");
        finish_load("reload");
        check_memory("reload");

        // Corrupted payload, then the resent frame
        start_load();
        fill_random();
        run_frame(8'd1, frame_checksum(), "frame 1 before retry");
        fill_random();
        good_sum       = frame_checksum();
        frame_data[17] = frame_data[17] ^ 8'hFF;
        run_frame(8'd2, good_sum, "corrupted frame 2");
        frame_data[17] = frame_data[17] ^ 8'hFF;
        run_frame(8'd2, frame_checksum(), "resent frame 2");
        finish_load("retry load");
        check_memory("retry load");

        // Bad inverted block number aborts the load
        start_load();
        fill_random();
        run_frame(8'd1, frame_checksum(), "frame 1 before abort");
        fill_random();
        bad_inv = ~8'd2 ^ 8'h10;
        send_frame(8'd2, bad_inv, frame_checksum());
        expect_reply(xmodem_pkg::NAK, "bad inverted block number");
        fill_random();
        send_frame(8'd3, ~8'd3, frame_checksum());
        send_byte(xmodem_pkg::EOT);
        watch_quiet(QUIET_CYCLES);
        // Idle loader leaves the bytes in the FIFO
        check_value("o_rx_full while aborted", {31'h0, rx_full}, 1);
        check_memory("aborted load");

        // Stop word in word 5 of the first frame
        start_load();
        @(negedge clk);
        check_value("o_rx_full after flush", {31'h0, rx_full}, 0);
        fill_random();
        for (int i = 20; i < 24; i++) begin
            frame_data[i] = 8'h1A;
        end
        run_frame(8'd1, frame_checksum(), "frame 1 with stop word");
        fill_random();
        run_frame(8'd2, frame_checksum(), "frame 2 after stop word");
        finish_load("stop word load");
        check_memory("stop word load");

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/xmodem_pkg.sv
logic/imem_pkg.sv
logic/byte_fifo.sv
logic/xmodem_loader.sv
logic/instr_mem.sv
logic/fw_load_top.sv
test/tb_clock.sv
test/tb_fw_load.sv

/* Makefile */
# Verilator build and run of the firmware load testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_fw_load -f flist.f -o Vtb_fw_load
	@out="$$(./obj_dir/Vtb_fw_load 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir
